// File: verilog/procyon_types.sv
// Procyon back end types
// Data, tag, opcode, CDB lane and dispatch/issue payload definitions.

`default_nettype none

package procyon_types;

    localparam int DATA_WIDTH = 32;
    localparam int TAG_WIDTH  = 6;
    localparam int CDB_DEPTH  = 2;   // One lane per functional unit.

    typedef logic [DATA_WIDTH-1:0] procyon_data_t;
    typedef logic [TAG_WIDTH-1:0]  procyon_tag_t;

    typedef enum logic [2:0] {
        OPCODE_ADD   = 3'd0,
        OPCODE_SUB   = 3'd1,
        OPCODE_AND   = 3'd2,
        OPCODE_OR    = 3'd3,
        OPCODE_XOR   = 3'd4,
        OPCODE_LOAD  = 3'd5,
        OPCODE_STORE = 3'd6
    } procyon_opcode_t;

    typedef struct packed {
        logic          en;
        procyon_tag_t  tag;
        procyon_data_t data;
    } procyon_cdb_t;

    typedef struct packed {
        procyon_opcode_t     opcode;
        procyon_tag_t        dst_tag;
        procyon_tag_t  [1:0] src_tag;
        procyon_data_t [1:0] src_data;
        logic          [1:0] src_rdy;
    } procyon_dispatch_t;

    // Payload from a station to its unit.
    typedef struct packed {
        procyon_opcode_t     opcode;
        procyon_tag_t        dst_tag;
        procyon_data_t [1:0] src_data;
    } procyon_issue_t;

endpackage

`default_nettype wire

// File: verilog/rs_switch.sv
// Reservation station switch
// Steers a dispatched instruction to the ALU or LSU station and
// bypasses source values from the CDB on the enqueue cycle.

`timescale 1ns/1ps
`default_nettype none

module rs_switch (
    input  procyon_types::procyon_cdb_t [procyon_types::CDB_DEPTH-1:0] i_cdb,

    input  logic                                i_rs_en,
    input  procyon_types::procyon_dispatch_t    i_rs_dispatch,
    input  logic [procyon_types::CDB_DEPTH-1:0] i_rs_stall,
    output logic [procyon_types::CDB_DEPTH-1:0] o_rs_en,
    output procyon_types::procyon_dispatch_t    o_rs_dispatch,
    output logic                                o_rs_stall
);

    import procyon_types::*;

    logic                      opcode_is_lsu;
    logic [CDB_DEPTH-1:0][1:0] cdb_bypass;     // Lane x source match.

    assign opcode_is_lsu = (i_rs_dispatch.opcode == OPCODE_LOAD) ||
                           (i_rs_dispatch.opcode == OPCODE_STORE);

    // Station 0 takes ALU ops, station 1 takes memory ops.
    assign o_rs_en    = {i_rs_en & opcode_is_lsu, i_rs_en & ~opcode_is_lsu};
    assign o_rs_stall = opcode_is_lsu ? i_rs_stall[1] : i_rs_stall[0];

    always_comb begin
        for (int cdb_idx = 0; cdb_idx < CDB_DEPTH; cdb_idx++) begin
            for (int src_idx = 0; src_idx < 2; src_idx++) begin
                cdb_bypass[cdb_idx][src_idx] =
                    i_cdb[cdb_idx].en &&
                    !i_rs_dispatch.src_rdy[src_idx] &&
                    (i_cdb[cdb_idx].tag == i_rs_dispatch.src_tag[src_idx]);
            end
        end
    end

    // A matching lane overrides a pending source with its value.
    always_comb begin
        o_rs_dispatch = i_rs_dispatch;
        for (int src_idx = 0; src_idx < 2; src_idx++) begin
            for (int cdb_idx = 0; cdb_idx < CDB_DEPTH; cdb_idx++) begin
                if (cdb_bypass[cdb_idx][src_idx]) begin
                    o_rs_dispatch.src_data[src_idx] = i_cdb[cdb_idx].data;
                    o_rs_dispatch.src_rdy[src_idx]  = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/reservation_station.sv
// Reservation station
// Holds waiting instructions, wakes pending sources from the CDB and
// issues ready entries to its functional unit, optionally in age order.

`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
    parameter int RS_DEPTH = 4,
    parameter bit IN_ORDER = 1'b0
) (
    input  logic                                i_clk,
    input  logic                                i_arst_n,

    input  logic                                i_en,
    input  procyon_types::procyon_dispatch_t    i_dispatch,
    input  procyon_types::procyon_cdb_t [procyon_types::CDB_DEPTH-1:0] i_cdb,
    input  logic                                i_fu_busy,
    output logic                                o_full,
    output logic                                o_issue_en,
    output procyon_types::procyon_issue_t       o_issue
);

    import procyon_types::*;

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
    localparam int AGE_W = $clog2(RS_DEPTH + 1);

    logic              [RS_DEPTH-1:0] entry_valid;
    logic [RS_DEPTH-1:0][AGE_W-1:0]   entry_age;    // 0 is the oldest.
    procyon_dispatch_t [RS_DEPTH-1:0] entries;
    logic              [RS_DEPTH-1:0] entry_rdy;
    logic                             issue_vld;
    logic [IDX_W-1:0]                 issue_idx;
    logic [IDX_W-1:0]                 free_idx;
    logic [AGE_W-1:0]                 valid_cnt;
    logic                             enq;

    always_comb begin
        issue_vld = 1'b0;
        issue_idx = '0;
        free_idx  = '0;
        valid_cnt = '0;
        // Walk downwards so the lowest index wins.
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            entry_rdy[i] = entry_valid[i] & (&entries[i].src_rdy);
            if (entry_rdy[i] && (!IN_ORDER || (entry_age[i] == '0))) begin
                issue_vld = 1'b1;
                issue_idx = IDX_W'(i);
            end
            if (!entry_valid[i]) free_idx = IDX_W'(i);
            valid_cnt = valid_cnt + AGE_W'(entry_valid[i]);
        end
    end

    assign o_full     = &entry_valid;
    assign enq        = i_en & ~o_full;    // Source holds while stalled.
    assign o_issue_en = issue_vld & ~i_fu_busy;

    always_comb begin
        o_issue.opcode   = entries[issue_idx].opcode;
        o_issue.dst_tag  = entries[issue_idx].dst_tag;
        o_issue.src_data = entries[issue_idx].src_data;
    end

    // Occupancy and age order.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            entry_valid <= '0;
            entry_age   <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (o_issue_en && (IDX_W'(i) == issue_idx)) begin
                    entry_valid[i] <= 1'b0;
                end else if (o_issue_en && (entry_age[i] > entry_age[issue_idx])) begin
                    entry_age[i] <= entry_age[i] - 1'b1;  // Younger ones move up.
                end
            end
            if (enq) begin
                entry_valid[free_idx] <= 1'b1;
                entry_age[free_idx]   <= valid_cnt - AGE_W'(o_issue_en);
            end
        end
    end

    // Payload with CDB wakeup; a new entry overrides its slot.
    always_ff @(posedge i_clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            for (int s = 0; s < 2; s++) begin
                for (int c = 0; c < CDB_DEPTH; c++) begin
                    if (entry_valid[i] && !entries[i].src_rdy[s] && i_cdb[c].en &&
                        (i_cdb[c].tag == entries[i].src_tag[s])) begin
                        entries[i].src_data[s] <= i_cdb[c].data;
                        entries[i].src_rdy[s]  <= 1'b1;
                    end
                end
            end
        end
        if (enq) entries[free_idx] <= i_dispatch;
    end

endmodule

`default_nettype wire

// File: verilog/alu_unit.sv
// ALU functional unit
// Computes one operation per issue and drives its CDB lane for a cycle.

`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  logic                           i_clk,
    input  logic                           i_arst_n,

    input  logic                           i_issue_en,
    input  procyon_types::procyon_issue_t  i_issue,
    output logic                           o_busy,
    output procyon_types::procyon_cdb_t    o_cdb
);

    import procyon_types::*;

    procyon_data_t result;
    logic          cdb_en;
    procyon_tag_t  cdb_tag;
    procyon_data_t cdb_data;

    always_comb begin
        case (i_issue.opcode)
            OPCODE_ADD: result = i_issue.src_data[0] + i_issue.src_data[1];
            OPCODE_SUB: result = i_issue.src_data[0] - i_issue.src_data[1];
            OPCODE_AND: result = i_issue.src_data[0] & i_issue.src_data[1];
            OPCODE_OR:  result = i_issue.src_data[0] | i_issue.src_data[1];
            OPCODE_XOR: result = i_issue.src_data[0] ^ i_issue.src_data[1];
            default:    result = '0;       // Memory ops never reach here.
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) cdb_en <= 1'b0;
        else           cdb_en <= i_issue_en;  // One cycle per issue.
    end

    always_ff @(posedge i_clk) begin
        if (i_issue_en) begin
            cdb_tag  <= i_issue.dst_tag;
            cdb_data <= result;
        end
    end

    assign o_cdb  = '{en: cdb_en, tag: cdb_tag, data: cdb_data};
    assign o_busy = cdb_en;    // Result on the lane.

endmodule

`default_nettype wire

// File: verilog/lsu_unit.sv
// Load/store functional unit
// Reads or writes a small data memory and broadcasts the loaded or stored value.

`timescale 1ns/1ps
`default_nettype none

module lsu_unit #(
    parameter int DMEM_DEPTH = 16
) (
    input  logic                           i_clk,
    input  logic                           i_arst_n,

    input  logic                           i_issue_en,
    input  procyon_types::procyon_issue_t  i_issue,
    output logic                           o_busy,
    output procyon_types::procyon_cdb_t    o_cdb
);

    import procyon_types::*;

    localparam int ADDR_W = (DMEM_DEPTH > 1) ? $clog2(DMEM_DEPTH) : 1;

    procyon_data_t dmem [DMEM_DEPTH];
    logic [ADDR_W-1:0] addr;
    procyon_data_t result;
    logic          cdb_en;
    procyon_tag_t  cdb_tag;
    procyon_data_t cdb_data;

    assign addr = ADDR_W'(i_issue.src_data[0] % DMEM_DEPTH);  // Word address.

    always_comb begin
        case (i_issue.opcode)
            OPCODE_LOAD:  result = dmem[addr];
            OPCODE_STORE: result = i_issue.src_data[1];   // Store echoes its value.
            default:      result = '0;
        endcase
    end

    // Data memory, cleared on reset.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (i_issue_en && (i_issue.opcode == OPCODE_STORE)) begin
            dmem[addr] <= i_issue.src_data[1];
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) cdb_en <= 1'b0;
        else           cdb_en <= i_issue_en;
    end

    always_ff @(posedge i_clk) begin
        if (i_issue_en) begin
            cdb_tag  <= i_issue.dst_tag;
            cdb_data <= result;
        end
    end

    assign o_cdb  = '{en: cdb_en, tag: cdb_tag, data: cdb_data};
    assign o_busy = cdb_en;

endmodule

`default_nettype wire

// File: verilog/procyon_backend.sv
// Procyon back end
// Switch, ALU and LSU reservation stations, their units and the two-lane CDB.

`timescale 1ns/1ps
`default_nettype none

module procyon_backend #(
    parameter int RS_DEPTH   = 4,
    parameter int DMEM_DEPTH = 16
) (
    input  logic                                i_clk,
    input  logic                                i_arst_n,

    input  logic                                i_dispatch_en,
    input  procyon_types::procyon_dispatch_t    i_dispatch,
    output logic                                o_dispatch_stall,
    output procyon_types::procyon_cdb_t [procyon_types::CDB_DEPTH-1:0] o_cdb
);

    import procyon_types::*;

    logic              [CDB_DEPTH-1:0] rs_en;
    logic              [CDB_DEPTH-1:0] rs_stall;     // Station full flags.
    procyon_dispatch_t                 rs_dispatch;
    logic              [CDB_DEPTH-1:0] issue_en;
    procyon_issue_t    [CDB_DEPTH-1:0] issue;
    logic              [CDB_DEPTH-1:0] fu_busy;

    rs_switch rs_switch_inst (
        .i_cdb         (o_cdb),
        .i_rs_en       (i_dispatch_en),
        .i_rs_dispatch (i_dispatch),
        .i_rs_stall    (rs_stall),
        .o_rs_en       (rs_en),
        .o_rs_dispatch (rs_dispatch),
        .o_rs_stall    (o_dispatch_stall)
    );

    // Station 0 feeds the ALU, station 1 the LSU in program order.
    for (genvar rs_idx = 0; rs_idx < CDB_DEPTH; rs_idx++) begin : gen_rs
        reservation_station #(
            .RS_DEPTH (RS_DEPTH),
            .IN_ORDER (rs_idx == 1)
        ) rs_inst (
            .i_clk      (i_clk),
            .i_arst_n   (i_arst_n),
            .i_en       (rs_en[rs_idx]),
            .i_dispatch (rs_dispatch),
            .i_cdb      (o_cdb),
            .i_fu_busy  (fu_busy[rs_idx]),
            .o_full     (rs_stall[rs_idx]),
            .o_issue_en (issue_en[rs_idx]),
            .o_issue    (issue[rs_idx])
        );
    end

    alu_unit alu_unit_inst (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_issue_en (issue_en[0]),
        .i_issue    (issue[0]),
        .o_busy     (fu_busy[0]),
        .o_cdb      (o_cdb[0])
    );

    lsu_unit #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) lsu_unit_inst (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_issue_en (issue_en[1]),
        .i_issue    (issue[1]),
        .o_busy     (fu_busy[1]),
        .o_cdb      (o_cdb[1])
    );

endmodule

`default_nettype wire

// File: tb/procyon_backend_properties.sv
// Back end assertions
// CDB lane and dispatch stall properties, bound to the top level.

`timescale 1ns/1ps
`default_nettype none

module procyon_backend_properties #(
    parameter int RS_DEPTH = 4
) (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic                i_dispatch_en,
    input  logic                i_dispatch_stall,
    input  procyon_types::procyon_cdb_t [procyon_types::CDB_DEPTH-1:0] i_cdb
);

    import procyon_types::*;

    localparam int CNT_W = $clog2(2 * RS_DEPTH + 3);

    logic [CNT_W-1:0] in_flight;    // Accepted and not yet broadcast.

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + CNT_W'(i_dispatch_en && !i_dispatch_stall)
                         - CNT_W'(i_cdb[0].en) - CNT_W'(i_cdb[1].en);
        end
    end

    for (genvar lane = 0; lane < CDB_DEPTH; lane++) begin : gen_lane
        cdb_quiet_in_reset: assert property (@(posedge i_clk) !i_arst_n |-> !i_cdb[lane].en)
            else $error("CDB lane %0d enabled during reset", lane);
        // A result is on its lane for exactly one cycle.
        cdb_single_cycle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
            i_cdb[lane].en |=> !i_cdb[lane].en)
            else $error("CDB lane %0d enabled for two cycles in a row", lane);
    end

    // Nothing in flight means both stations have drained.
    stall_low_when_empty: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (in_flight == '0) |-> !i_dispatch_stall)
        else $error("Dispatch stalled while both stations are empty");

endmodule

bind procyon_backend procyon_backend_properties #(
    .RS_DEPTH (RS_DEPTH)
) i_props (
    .i_clk            (i_clk),
    .i_arst_n         (i_arst_n),
    .i_dispatch_en    (i_dispatch_en),
    .i_dispatch_stall (o_dispatch_stall),
    .i_cdb            (o_cdb)
);

`default_nettype wire

// File: tb/tb_procyon_backend.sv
// Back end testbench
// Plays the dispatch stage with LFSR stimulus and checks every CDB broadcast
// against a program-order model of tag values and data memory.

`timescale 1ns/1ps
`default_nettype none

module tb_procyon_backend;

    import procyon_types::*;

    localparam int RS_DEPTH    = 4;
    localparam int DMEM_DEPTH  = 16;
    localparam int NUM_TAGS    = 2**TAG_WIDTH;
    localparam int STALL_LIMIT = 100;

    logic                              clk;
    logic                              arst_n;
    logic                              dispatch_en;
    procyon_dispatch_t                 dispatch_pkt;
    logic                              dispatch_stall;
    procyon_cdb_t      [CDB_DEPTH-1:0] cdb;

    logic [31:0]         lfsr_state;
    procyon_data_t       model_val [NUM_TAGS];
    procyon_data_t       model_mem [DMEM_DEPTH];
    logic [NUM_TAGS-1:0] dispatched;
    logic [NUM_TAGS-1:0] seen;             // Tag already broadcast.
    procyon_tag_t        lsu_order [$];    // Memory ops in program order.
    int                  next_tag;
    int                  stall_cycles;
    int                  data_errors;
    int                  tag_errors;
    int                  other_errors;

    procyon_backend #(
        .RS_DEPTH   (RS_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) i_dut (
        .i_clk            (clk),
        .i_arst_n         (arst_n),
        .i_dispatch_en    (dispatch_en),
        .i_dispatch       (dispatch_pkt),
        .o_dispatch_stall (dispatch_stall),
        .o_cdb            (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Expected broadcast value, evaluated in program order.
    function automatic procyon_data_t ref_value(input procyon_opcode_t op,
                                                input procyon_data_t a, input procyon_data_t b);
        case (op)
            OPCODE_ADD:   return a + b;
            OPCODE_SUB:   return a - b;
            OPCODE_AND:   return a & b;
            OPCODE_OR:    return a | b;
            OPCODE_XOR:   return a ^ b;
            OPCODE_LOAD:  return model_mem[a % DMEM_DEPTH];
            default:      return b;    // Store echoes its data.
        endcase
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (dispatched[t] && !seen[t]) n++;
        end
        return n;
    endfunction

    task automatic check_data(input procyon_tag_t tag, input procyon_data_t got,
                              input procyon_data_t exp);
        if (got !== exp) begin
            data_errors++;
            $display("Fail at %0t: tag %0d broadcast %h, expected %h", $time, tag, got, exp);
        end
    endtask

    task automatic check_tag(input procyon_tag_t got, input procyon_tag_t exp);
        if (got !== exp) begin
            tag_errors++;
            $display("Fail at %0t: LSU lane tag %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic compare_lane(input int lane, input procyon_cdb_t bus);
        procyon_tag_t exp_tag;
        if (lane == 1) begin
            if (lsu_order.size() == 0) begin
                other_errors++;
                $display("LSU lane broadcast tag %0d with no memory op outstanding", bus.tag);
            end else begin
                exp_tag = lsu_order.pop_front();
                check_tag(bus.tag, exp_tag);
            end
        end
        if (!dispatched[bus.tag]) begin
            other_errors++;
            $display("Tag %0d was broadcast on lane %0d but never dispatched", bus.tag, lane);
        end else if (seen[bus.tag]) begin
            other_errors++;
            $display("Tag %0d was broadcast a second time on lane %0d", bus.tag, lane);
        end else begin
            seen[bus.tag] = 1'b1;
            check_data(bus.tag, bus.data, model_val[bus.tag]);
        end
    endtask

    // Pre-edge values of the CDB.
    always @(posedge clk) begin
        if (arst_n) begin
            for (int lane = 0; lane < CDB_DEPTH; lane++) begin
                if (cdb[lane].en) compare_lane(lane, cdb[lane]);
            end
        end
    end

    // Called on a falling edge; returns on the falling edge after acceptance.
    task automatic send_instr(input procyon_opcode_t op, input logic [1:0] dep,
                              input procyon_tag_t [1:0] ptag, input procyon_data_t [1:0] lit);
        procyon_tag_t        tag;
        procyon_data_t [1:0] opnd;
        int                  waited;
        logic                taken;
        tag    = procyon_tag_t'(next_tag);
        waited = 0;
        taken  = 1'b0;
        next_tag++;
        for (int s = 0; s < 2; s++) opnd[s] = dep[s] ? model_val[ptag[s]] : lit[s];
        model_val[tag]  = ref_value(op, opnd[0], opnd[1]);
        if (op == OPCODE_STORE) model_mem[opnd[0] % DMEM_DEPTH] = opnd[1];
        dispatched[tag] = 1'b1;
        while (!taken && (waited < STALL_LIMIT)) begin
            dispatch_pkt.opcode  = op;
            dispatch_pkt.dst_tag = tag;
            // Operand state is re-read while the instruction waits.
            for (int s = 0; s < 2; s++) begin
                dispatch_pkt.src_tag[s] = dep[s] ? ptag[s] : '0;
                if (dep[s] && !seen[ptag[s]]) begin
                    dispatch_pkt.src_rdy[s]  = 1'b0;
                    dispatch_pkt.src_data[s] = ~opnd[s];    // Junk until woken.
                end else begin
                    dispatch_pkt.src_rdy[s]  = 1'b1;
                    dispatch_pkt.src_data[s] = opnd[s];
                end
            end
            dispatch_en = 1'b1;
            @(posedge clk);
            taken = !dispatch_stall;
            if (!taken) stall_cycles++;
            @(negedge clk);
            waited++;
        end
        if (!taken) begin
            other_errors++;
            $display("Dispatch of tag %0d still stalled after %0d cycles", tag, waited);
            dispatched[tag] = 1'b0;
            dispatch_en     = 1'b0;
        end else if ((op == OPCODE_LOAD) || (op == OPCODE_STORE)) begin
            lsu_order.push_back(tag);
        end
    endtask

    // Mode 0 is ALU ops on literals, 1 is mixed with dependences, 2 is memory only.
    task automatic random_instr(input int mode);
        procyon_opcode_t     op;
        logic          [1:0] dep;
        procyon_tag_t  [1:0] ptag;
        procyon_data_t [1:0] lit;
        if (mode == 2) op = (take_bits(1) != 0) ? OPCODE_LOAD : OPCODE_STORE;
        else if (mode == 1) op = procyon_opcode_t'(take_bits(3) % 7);
        else op = procyon_opcode_t'(take_bits(3) % 5);
        for (int s = 0; s < 2; s++) begin
            dep[s]  = (mode != 0) && (take_bits(1) != 0);
            ptag[s] = procyon_tag_t'(next_tag - 1 - int'(take_bits(3)));  // One of the last 8.
            lit[s]  = take_bits(32);
        end
        if (mode == 2) begin
            dep[0] = 1'b0;
            lit[0] = take_bits(4);    // Narrow addresses so accesses collide.
        end
        send_instr(op, dep, ptag, lit);
    endtask

    task automatic drain(input int limit);
        int waited;
        waited = 0;
        while ((pending_count() > 0) && (waited < limit)) begin
            @(negedge clk);
            waited++;
        end
        if (pending_count() > 0) begin
            other_errors++;
            $display("%0d dispatched tags not broadcast within %0d cycles", pending_count(), limit);
        end
    endtask

    task automatic wait_for_cdb_tag(input procyon_tag_t tag);
        int waited;
        waited = 0;
        while (!(cdb[0].en && (cdb[0].tag == tag)) && (waited < 20)) begin
            @(negedge clk);
            waited++;
        end
        if (!(cdb[0].en && (cdb[0].tag == tag))) begin
            other_errors++;
            $display("Tag %0d never appeared on the ALU lane", tag);
        end
    endtask

    initial begin
        procyon_tag_t        producer;
        procyon_data_t [1:0] lit;
        lfsr_state   = 32'h1109;
        next_tag     = 0;
        stall_cycles = 0;
        data_errors  = 0;
        tag_errors   = 0;
        other_errors = 0;
        dispatched   = '0;
        seen         = '0;
        for (int i = 0; i < DMEM_DEPTH; i++) model_mem[i] = '0;
        arst_n       = 1'b0;
        dispatch_en  = 1'b0;
        dispatch_pkt = '0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;

        repeat (8) random_instr(0);
        dispatch_en = 1'b0;
        drain(200);
        repeat (16) random_instr(1);
        dispatch_en = 1'b0;
        drain(400);
        repeat (12) random_instr(2);
        dispatch_en = 1'b0;
        drain(400);

        // Consumer enters while its producer is on the CDB.
        repeat (3) begin
            producer = procyon_tag_t'(next_tag);
            lit      = {take_bits(32), take_bits(32)};
            send_instr(OPCODE_ADD, 2'b00, '0, lit);
            dispatch_en = 1'b0;
            wait_for_cdb_tag(producer);
            lit = {take_bits(32), 32'd0};
            send_instr(OPCODE_XOR, 2'b01, {procyon_tag_t'(0), producer}, lit);
            dispatch_en = 1'b0;
        end
        drain(200);

        // Dependent chain, dispatched back to back.
        stall_cycles = 0;
        lit = {take_bits(32), take_bits(32)};
        send_instr(OPCODE_SUB, 2'b00, '0, lit);
        repeat (13) begin
            producer = procyon_tag_t'(next_tag - 1);
            lit      = {take_bits(32), 32'd0};
            send_instr(procyon_opcode_t'(take_bits(3) % 5), 2'b01,
                       {procyon_tag_t'(0), producer}, lit);
        end
        dispatch_en = 1'b0;
        if (stall_cycles == 0) begin
            other_errors++;
            $display("The ALU station never filled during the dependent burst");
        end
        drain(400);
        repeat (4) @(negedge clk);

        $display("Errors: data %0d, tag %0d, other %0d", data_errors, tag_errors, other_errors);
        if ((data_errors + tag_errors + other_errors) == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
verilog/procyon_types.sv
verilog/rs_switch.sv
verilog/reservation_station.sv
verilog/alu_unit.sv
verilog/lsu_unit.sv
verilog/procyon_backend.sv
tb/procyon_backend_properties.sv
tb/tb_procyon_backend.sv
